//--- include/ex_config.svh
// Widths and sizes shared by the execute stage packages and RTL; include wherever a width is needed
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Register, immediate and PC width
`define EX_XLEN 64

// Register number width
`define EX_REGNO_W 5

// Low half used by the 32-bit W forms
`define EX_WORD_W 32

// Shift amounts, 64-bit forms and W forms
`define EX_SHAMT_W 6
`define EX_SHAMTW_W 5

`define EX_INSN_BYTES 4

`endif

//--- verilog/ex_types_pkg.sv
// Data-path vector types of the execute stage; imported by every RTL module of the stage
`include "ex_config.svh"

package ex_types_pkg;

    // Register value, immediate and PC
    typedef logic [`EX_XLEN-1:0] xlen_t;

    // Register number, x0 is hard-wired zero
    typedef logic [`EX_REGNO_W-1:0] regno_t;

    // Operand half for the W forms
    typedef logic [`EX_WORD_W-1:0] word_t;

    // Shift amount of the 64-bit forms
    typedef logic [`EX_SHAMT_W-1:0] shamt_t;

endpackage

//--- verilog/ex_op_pkg.sv
// Opcode enum and operation grouping of the execute stage; imported by the ALU, branch unit and buffer
`include "ex_config.svh"

package ex_op_pkg;

    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LUI, OP_AUIPC,
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
        OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
        OP_SB, OP_SH, OP_SW, OP_SD,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR
    } ex_op_t;

    typedef enum logic [2:0] {
        GRP_NONE,
        GRP_ALU_REG,
        GRP_ALU_IMM,
        GRP_LOAD,
        GRP_STORE,
        GRP_BRANCH,
        GRP_JUMP
    } op_group_t;

    function automatic op_group_t op_group(input ex_op_t op);
        case (op)
            OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
            OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW:
                return GRP_ALU_REG;
            OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
            OP_LUI, OP_AUIPC, OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW:
                return GRP_ALU_IMM;
            OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU:
                return GRP_LOAD;
            OP_SB, OP_SH, OP_SW, OP_SD:
                return GRP_STORE;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
                return GRP_BRANCH;
            OP_JAL, OP_JALR:
                return GRP_JUMP;
            default:
                return GRP_NONE;
        endcase
    endfunction

    function automatic logic op_is_word(input ex_op_t op);
        return op inside {OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
                          OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW};
    endfunction

    // W forms only look at the low 5 bits of the shift amount
    function automatic logic [`EX_SHAMT_W-1:0] shamt_mask(input ex_op_t op);
        logic [`EX_SHAMT_W-1:0] mask;
        mask = '1;
        if (op_is_word(op))
        begin
            mask = '0;
            mask[`EX_SHAMTW_W-1:0] = '1;
        end
        return mask;
    endfunction

endpackage

//--- verilog/operand_forward.sv
// Operand selection across the forwarding sources plus load-use hazard detection; used by the stage top
`timescale 1ns/1ps

module operand_forward
    import ex_types_pkg::*;
(
    input  regno_t rs1_regno,
    input  regno_t rs2_regno,
    input  xlen_t  rs1_value,
    input  xlen_t  rs2_value,
    input  logic   issue,

    // Own output buffer
    input  regno_t ex_rd_regno,
    input  logic   ex_write_rd,
    input  logic   ex_mm_load,
    input  xlen_t  ex_result,

    // Memory stage
    input  regno_t mm_rd_regno,
    input  logic   mm_write_rd,
    input  logic   mm_load,
    input  xlen_t  mm_alu_result,
    input  xlen_t  mm_mdata,

    // Write-back stage
    input  regno_t wb_rd_regno,
    input  logic   wb_write_rd,
    input  xlen_t  wb_data,

    output xlen_t  src1,
    output xlen_t  src2,
    output logic   hazard
);

    logic load_in_buffer;

    // Youngest producer wins; a load still in the buffer is left to the stall
    function automatic xlen_t forward(input regno_t regno, input xlen_t rf_value);
        xlen_t value;
        value = rf_value;
        if (regno == '0)
        begin
            value = rf_value;
        end
        else if (ex_write_rd && !ex_mm_load && ex_rd_regno == regno)
        begin
            value = ex_result;
        end
        else if (mm_write_rd && mm_rd_regno == regno)
        begin
            value = mm_load ? mm_mdata : mm_alu_result;
        end
        else if (wb_write_rd && wb_rd_regno == regno)
        begin
            value = wb_data;
        end
        return value;
    endfunction

    always_comb
    begin
        src1 = forward(rs1_regno, rs1_value);
        src2 = forward(rs2_regno, rs2_value);
    end

    assign load_in_buffer = ex_write_rd && ex_mm_load && (ex_rd_regno != '0);

    // Load data only exists once the load reaches the memory stage
    assign hazard = issue && load_in_buffer &&
                    (ex_rd_regno == rs1_regno || ex_rd_regno == rs2_regno);

endmodule

//--- verilog/int_alu.sv
// RV64I integer ALU, also address and link computation; combinational, feeds the result buffer
`timescale 1ns/1ps
`include "ex_config.svh"

module int_alu
    import ex_types_pkg::*, ex_op_pkg::*;
(
    input  ex_op_t op,
    input  xlen_t  src1,
    input  xlen_t  src2,
    input  xlen_t  imm,
    input  xlen_t  pc_next,
    output xlen_t  result,
    output logic   write_rd,
    output logic   mm_load
);

    op_group_t op_grp;
    xlen_t     opb;
    shamt_t    shamt;
    word_t     src1_w;
    word_t     opb_w;
    word_t     word_res;
    xlen_t     full_res;

    assign op_grp = op_group(op);

    // Register forms use rs2, every other op uses the immediate
    assign opb    = (op_grp == GRP_ALU_REG) ? src2 : imm;
    assign shamt  = opb[`EX_SHAMT_W-1:0] & shamt_mask(op);
    assign src1_w = src1[`EX_WORD_W-1:0];
    assign opb_w  = opb[`EX_WORD_W-1:0];

    always_comb
    begin
        full_res = '0;
        word_res = '0;
        case (op)
            OP_ADD, OP_ADDI,
            OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
            OP_SB, OP_SH, OP_SW, OP_SD:
                full_res = src1 + opb;
            OP_SUB:
                full_res = src1 - opb;
            OP_SLL, OP_SLLI:
                full_res = src1 << shamt;
            OP_SLT, OP_SLTI:
                full_res = xlen_t'($signed(src1) < $signed(opb));
            OP_SLTU, OP_SLTIU:
                full_res = xlen_t'(src1 < opb);
            OP_XOR, OP_XORI:
                full_res = src1 ^ opb;
            OP_SRL, OP_SRLI:
                full_res = src1 >> shamt;
            OP_SRA, OP_SRAI:
                full_res = $signed(src1) >>> shamt;
            OP_OR, OP_ORI:
                full_res = src1 | opb;
            OP_AND, OP_ANDI:
                full_res = src1 & opb;
            OP_LUI:
                full_res = imm;
            OP_AUIPC:
                full_res = pc_next - xlen_t'(`EX_INSN_BYTES) + imm;
            // Link value
            OP_JAL, OP_JALR:
                full_res = pc_next;
            OP_ADDW, OP_ADDIW:
                word_res = src1_w + opb_w;
            OP_SUBW:
                word_res = src1_w - opb_w;
            OP_SLLW, OP_SLLIW:
                word_res = src1_w << shamt;
            OP_SRLW, OP_SRLIW:
                word_res = src1_w >> shamt;
            OP_SRAW, OP_SRAIW:
                word_res = $signed(src1_w) >>> shamt;
            default:
                full_res = '0;
        endcase
    end

    // W results are sign-extended from bit 31
    assign result = op_is_word(op) ?
                    {{(`EX_XLEN-`EX_WORD_W){word_res[`EX_WORD_W-1]}}, word_res} :
                    full_res;

    assign write_rd = op_grp inside {GRP_ALU_REG, GRP_ALU_IMM, GRP_LOAD, GRP_JUMP};
    assign mm_load  = (op_grp == GRP_LOAD);

endmodule

//--- verilog/branch_unit.sv
// Branch decision and next-PC target for conditional branches and jumps; combinational
`timescale 1ns/1ps
`include "ex_config.svh"

module branch_unit
    import ex_types_pkg::*, ex_op_pkg::*;
(
    input  ex_op_t op,
    input  xlen_t  src1,
    input  xlen_t  src2,
    input  xlen_t  imm,
    input  xlen_t  pc_next,
    output logic   taken,
    output xlen_t  target
);

    xlen_t insn_addr;
    xlen_t br_target;
    xlen_t jalr_sum;

    // pc_next points past the instruction, targets are relative to its own address
    assign insn_addr = pc_next - xlen_t'(`EX_INSN_BYTES);
    assign br_target = insn_addr + imm;
    assign jalr_sum  = src1 + imm;

    always_comb
    begin
        case (op)
            OP_BEQ:  taken = (src1 == src2);
            OP_BNE:  taken = (src1 != src2);
            OP_BLT:  taken = ($signed(src1) < $signed(src2));
            OP_BGE:  taken = ($signed(src1) >= $signed(src2));
            OP_BLTU: taken = (src1 < src2);
            OP_BGEU: taken = (src1 >= src2);
            OP_JAL:  taken = 1'b1;
            OP_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase

        if (op == OP_JALR)
        begin
            target = {jalr_sum[`EX_XLEN-1:1], 1'b0};
        end
        else if (taken)
        begin
            target = br_target;
        end
        else
        begin
            // Not taken falls through
            target = pc_next;
        end
    end

endmodule

//--- verilog/ex_result_reg.sv
// Execute stage output buffer; one cycle latency, loads a bubble on stall, squash, flush or idle
`timescale 1ns/1ps

module ex_result_reg
    import ex_types_pkg::*, ex_op_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   flush,
    input  logic   accept,

    input  ex_op_t op,
    input  regno_t rd_regno,
    input  xlen_t  result,
    input  xlen_t  store_data,
    input  logic   write_rd,
    input  logic   mm_load,
    input  logic   taken,
    input  xlen_t  target,

    output ex_op_t ex_op,
    output regno_t ex_rd_regno,
    output xlen_t  ex_result,
    output xlen_t  ex_store_data,
    output logic   ex_write_rd,
    output logic   ex_mm_load,
    output logic   ex_branch_taken,
    output xlen_t  ex_target
);

    logic load_insn;

    // Instruction behind a taken branch is dropped; unknown ops also leave a bubble
    assign load_insn = !flush && accept && !ex_branch_taken && (op_group(op) != GRP_NONE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_op           <= OP_NOP;
            ex_write_rd     <= 1'b0;
            ex_mm_load      <= 1'b0;
            ex_branch_taken <= 1'b0;
        end
        else
        begin
            ex_op           <= load_insn ? op : OP_NOP;
            ex_write_rd     <= load_insn && write_rd;
            ex_mm_load      <= load_insn && mm_load;
            ex_branch_taken <= load_insn && taken;
        end
    end

    // Bubbles carry zero data
    always_ff @(posedge clk)
    begin
        ex_rd_regno   <= load_insn ? rd_regno : '0;
        ex_result     <= load_insn ? result : '0;
        ex_store_data <= load_insn ? store_data : '0;
        ex_target     <= load_insn ? target : '0;
    end

endmodule

//--- verilog/execute_stage.sv
// Top of the RV64I execute stage; connects forwarding, ALU, branch unit and the output buffer
`timescale 1ns/1ps

module execute_stage
    import ex_types_pkg::*, ex_op_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    // Decode stage
    input  logic   issue,
    input  ex_op_t op,
    input  regno_t rs1_regno,
    input  regno_t rs2_regno,
    input  regno_t rd_regno,
    input  xlen_t  rs1_value,
    input  xlen_t  rs2_value,
    input  xlen_t  imm,
    input  xlen_t  pc_next,

    // Memory stage
    input  regno_t mm_rd_regno,
    input  logic   mm_write_rd,
    input  logic   mm_load,
    input  xlen_t  mm_alu_result,
    input  xlen_t  mm_mdata,

    // Write-back stage
    input  regno_t wb_rd_regno,
    input  logic   wb_write_rd,
    input  xlen_t  wb_data,

    input  logic   flush,

    output logic   ready,
    output ex_op_t ex_op,
    output regno_t ex_rd_regno,
    output xlen_t  ex_result,
    output xlen_t  ex_store_data,
    output logic   ex_write_rd,
    output logic   ex_mm_load,
    output logic   ex_branch_taken,
    output xlen_t  ex_target
);

    xlen_t src1;
    xlen_t src2;
    logic  hazard;
    xlen_t alu_result;
    logic  alu_write_rd;
    logic  alu_mm_load;
    logic  br_taken;
    xlen_t br_target;

    assign ready = !hazard;

    operand_forward u_forward (
        .rs1_regno     (rs1_regno),
        .rs2_regno     (rs2_regno),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .issue         (issue),
        .ex_rd_regno   (ex_rd_regno),
        .ex_write_rd   (ex_write_rd),
        .ex_mm_load    (ex_mm_load),
        .ex_result     (ex_result),
        .mm_rd_regno   (mm_rd_regno),
        .mm_write_rd   (mm_write_rd),
        .mm_load       (mm_load),
        .mm_alu_result (mm_alu_result),
        .mm_mdata      (mm_mdata),
        .wb_rd_regno   (wb_rd_regno),
        .wb_write_rd   (wb_write_rd),
        .wb_data       (wb_data),
        .src1          (src1),
        .src2          (src2),
        .hazard        (hazard)
    );

    int_alu u_alu (
        .op       (op),
        .src1     (src1),
        .src2     (src2),
        .imm      (imm),
        .pc_next  (pc_next),
        .result   (alu_result),
        .write_rd (alu_write_rd),
        .mm_load  (alu_mm_load)
    );

    branch_unit u_branch (
        .op      (op),
        .src1    (src1),
        .src2    (src2),
        .imm     (imm),
        .pc_next (pc_next),
        .taken   (br_taken),
        .target  (br_target)
    );

    ex_result_reg u_result (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .accept          (issue && ready),
        .op              (op),
        .rd_regno        (rd_regno),
        .result          (alu_result),
        .store_data      (src2),
        .write_rd        (alu_write_rd),
        .mm_load         (alu_mm_load),
        .taken           (br_taken),
        .target          (br_target),
        .ex_op           (ex_op),
        .ex_rd_regno     (ex_rd_regno),
        .ex_result       (ex_result),
        .ex_store_data   (ex_store_data),
        .ex_write_rd     (ex_write_rd),
        .ex_mm_load      (ex_mm_load),
        .ex_branch_taken (ex_branch_taken),
        .ex_target       (ex_target)
    );

endmodule

//--- sim/ex_tb_clock.sv
// Testbench clock and reset source for the execute stage testbench; 10 ns period, reset held 3 cycles
`timescale 1ns/1ps

module ex_tb_clock
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- sim/execute_stage_tb.sv
// Directed testbench of the execute stage; models ALU, branch unit and the memory and write-back stages
`timescale 1ns/1ps

module execute_stage_tb
    import ex_types_pkg::*, ex_op_pkg::*;
();

    logic clk, reset, issue, flush, ready;
    ex_op_t op, ex_op;
    regno_t rs1_regno, rs2_regno, rd_regno, mm_rd_regno, wb_rd_regno, ex_rd_regno;
    xlen_t rs1_value, rs2_value, imm, pc_next, mm_alu_result, mm_mdata, wb_data;
    xlen_t ex_result, ex_store_data, ex_target;
    logic mm_write_rd, mm_load, wb_write_rd, ex_write_rd, ex_mm_load, ex_branch_taken;
    int errors = 0;
    int checks = 0;
    int seed = 11;

    ex_tb_clock clock0 (.clk(clk), .reset(reset));

    execute_stage dut0 (.*);

    function automatic xlen_t sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // Reference ALU written from the RV64I rules
    function automatic xlen_t alu_model(input ex_op_t o, input xlen_t a, input xlen_t b,
                                        input xlen_t i, input xlen_t pc);
        case (o)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_SLL:   return a << b[5:0];
            OP_SLT:   return {63'b0, $signed(a) < $signed(b)};
            OP_SLTU:  return {63'b0, a < b};
            OP_XOR:   return a ^ b;
            OP_SRL:   return a >> b[5:0];
            OP_SRA:   return $signed(a) >>> b[5:0];
            OP_OR:    return a | b;
            OP_AND:   return a & b;
            OP_ADDI:  return a + i;
            OP_SLTI:  return {63'b0, $signed(a) < $signed(i)};
            OP_SLTIU: return {63'b0, a < i};
            OP_XORI:  return a ^ i;
            OP_ORI:   return a | i;
            OP_ANDI:  return a & i;
            OP_SLLI:  return a << i[5:0];
            OP_SRLI:  return a >> i[5:0];
            OP_SRAI:  return $signed(a) >>> i[5:0];
            OP_LUI:   return i;
            OP_AUIPC: return pc - 64'd4 + i;
            OP_ADDW:  return sext32(a[31:0] + b[31:0]);
            OP_SUBW:  return sext32(a[31:0] - b[31:0]);
            OP_SLLW:  return sext32(a[31:0] << b[4:0]);
            OP_SRLW:  return sext32(a[31:0] >> b[4:0]);
            OP_SRAW:  return sext32($signed(a[31:0]) >>> b[4:0]);
            OP_ADDIW: return sext32(a[31:0] + i[31:0]);
            OP_SLLIW: return sext32(a[31:0] << i[4:0]);
            OP_SRLIW: return sext32(a[31:0] >> i[4:0]);
            OP_SRAIW: return sext32($signed(a[31:0]) >>> i[4:0]);
            default:  return 64'd0;
        endcase
    endfunction

    function automatic logic branch_model(input ex_op_t o, input xlen_t a, input xlen_t b);
        case (o)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLT:  return $signed(a) < $signed(b);
            OP_BGE:  return $signed(a) >= $signed(b);
            OP_BLTU: return a < b;
            OP_BGEU: return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    // Memory model contents, every address bit matters
    function automatic xlen_t mem_data(input xlen_t addr);
        return {addr[31:0] ^ 32'h5a5a_0f0f, ~addr[63:32]} + addr;
    endfunction

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic check(input string name, input xlen_t exp, input xlen_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    endtask

    task automatic set_insn(input ex_op_t o, input regno_t r1, input regno_t r2, input regno_t rd,
                            input xlen_t v1, input xlen_t v2, input xlen_t i, input xlen_t pc);
        issue     <= 1'b1;
        op        <= o;
        rs1_regno <= r1;
        rs2_regno <= r2;
        rd_regno  <= rd;
        rs1_value <= v1;
        rs2_value <= v2;
        imm       <= i;
        pc_next   <= pc;
    endtask

    task automatic set_bypass(input regno_t mrd, input logic mw, input logic ml, input xlen_t ma,
                              input xlen_t md, input regno_t wrd, input logic ww, input xlen_t wd);
        @(posedge clk);
        mm_rd_regno   <= mrd;
        mm_write_rd   <= mw;
        mm_load       <= ml;
        mm_alu_result <= ma;
        mm_mdata      <= md;
        wb_rd_regno   <= wrd;
        wb_write_rd   <= ww;
        wb_data       <= wd;
    endtask

    // Returns on the rising edge where issue and ready are both high
    task automatic wait_accept();
        int n;
        n = 0;
        @(negedge clk);
        while (!ready && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (!ready)
        begin
            errors++;
            $display("timeout: ready stayed low at %0t", $time);
            finish_run();
        end
        else
            @(posedge clk);
    endtask

    task automatic run_insn(input ex_op_t o, input regno_t r1, input regno_t r2, input regno_t rd,
                            input xlen_t v1, input xlen_t v2, input xlen_t i, input xlen_t pc);
        @(posedge clk);
        set_insn(o, r1, r2, rd, v1, v2, i, pc);
        wait_accept();
        issue <= 1'b0;
        @(negedge clk);
    endtask

    task automatic test_reset_state();
        int n;
        n = 0;
        // A valid instruction is offered on a reset edge, only reset keeps it out
        @(posedge clk);
        set_insn(OP_ADDI, 5'd1, 5'd0, 5'd3, 64'd1, 64'd0, 64'd1, 64'h4);
        @(posedge clk);
        issue <= 1'b0;
        @(negedge clk);
        check("reset ex_op", 64'(OP_NOP), 64'(ex_op));
        check("reset ex_write_rd", 64'd0, 64'(ex_write_rd));
        while (reset && n < 50)
        begin
            @(posedge clk);
            n++;
        end
        if (reset)
        begin
            errors++;
            $display("timeout: reset was never released at %0t", $time);
            finish_run();
        end
        else
        begin
            @(negedge clk);
            check("ex_op", 64'(OP_NOP), 64'(ex_op));
            check("ex_write_rd", 64'd0, 64'(ex_write_rd));
            check("ex_mm_load", 64'd0, 64'(ex_mm_load));
            check("ex_branch_taken", 64'd0, 64'(ex_branch_taken));
        end
    endtask

    task automatic test_alu();
        ex_op_t ops[30] = '{OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA,
            OP_OR, OP_AND, OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI,
            OP_SRLI, OP_SRAI, OP_LUI, OP_AUIPC, OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
            OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW};
        xlen_t a, b, i, pc;
        foreach (ops[n])
        begin
            for (int k = 0; k < 4; k++)
            begin
                a = (k == 0) ? 64'h8000_0000_0000_0000 : (k == 1) ? 64'h0000_0000_7fff_ffff
                                                                  : rand64();
                b = (k == 0) ? 64'hffff_ffff_ffff_ffc1 : (k == 1) ? 64'h0000_0000_0000_0001
                                                                  : rand64();
                i = (k == 1) ? 64'h0000_0000_0000_003f : rand64();
                pc = rand64() & ~64'd3;
                run_insn(ops[n], 5'd1, 5'd2, 5'd3, a, b, i, pc);
                check(ops[n].name(), alu_model(ops[n], a, b, i, pc), ex_result);
                check("ex_op", 64'(ops[n]), 64'(ex_op));
                check("ex_rd_regno", 64'd3, 64'(ex_rd_regno));
                check("ex_write_rd", 64'd1, 64'(ex_write_rd));
                check("ex_mm_load", 64'd0, 64'(ex_mm_load));
            end
        end
    endtask

    task automatic test_mem_addr();
        ex_op_t ops[11] = '{OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
                            OP_SB, OP_SH, OP_SW, OP_SD};
        xlen_t a, b, i;
        logic is_load;
        foreach (ops[n])
        begin
            a = rand64();
            b = rand64();
            i = {{52{1'b1}}, 12'h9f0};
            is_load = (n < 7);
            run_insn(ops[n], 5'd4, 5'd6, 5'd8, a, b, i, 64'h1000);
            check("ex_result addr", a + i, ex_result);
            check("ex_mm_load", 64'(is_load), 64'(ex_mm_load));
            check("ex_write_rd", 64'(is_load), 64'(ex_write_rd));
            check("ex_store_data", b, ex_store_data);
        end
    endtask

    task automatic test_branches();
        ex_op_t ops[8] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JAL, OP_JALR};
        xlen_t av[4] = '{64'd5, 64'd5, 64'hffff_ffff_ffff_ffff, 64'd1};
        xlen_t bv[4] = '{64'd5, 64'd7, 64'd1, 64'hffff_ffff_ffff_ffff};
        xlen_t i, pc, exp_target;
        logic exp_taken;
        foreach (ops[n])
        begin
            for (int k = 0; k < 4; k++)
            begin
                i = (k[0]) ? 64'hffff_ffff_ffff_fff0 : 64'h0000_0000_0000_0123;
                pc = 64'h0000_0000_0040_0100;
                exp_taken = branch_model(ops[n], av[k], bv[k]);
                if (ops[n] == OP_JALR)
                    exp_target = (av[k] + i) & ~64'd1;
                else
                    exp_target = exp_taken ? pc - 64'd4 + i : pc;
                run_insn(ops[n], 5'd10, 5'd11, 5'd12, av[k], bv[k], i, pc);
                check({ops[n].name(), " taken"}, 64'(exp_taken), 64'(ex_branch_taken));
                check("ex_target", exp_target, ex_target);
                if (ops[n] == OP_JAL || ops[n] == OP_JALR)
                    check("link ex_result", pc, ex_result);
            end
        end
    endtask

    task automatic test_forwarding();
        // Buffer beats a matching memory stage
        set_bypass(5'd7, 1'b1, 1'b0, 64'hdead, 64'd0, 5'd7, 1'b1, 64'hbeef);
        @(posedge clk);
        set_insn(OP_ADDI, 5'd1, 5'd0, 5'd7, 64'd100, 64'd0, 64'd5, 64'h2000);
        wait_accept();
        set_insn(OP_ADD, 5'd7, 5'd2, 5'd9, 64'd999, 64'd3, 64'd0, 64'h2004);
        wait_accept();
        issue <= 1'b0;
        @(negedge clk);
        check("fwd buffer", 64'd108, ex_result);
        // Memory stage beats write-back
        set_bypass(5'd9, 1'b1, 1'b0, 64'h111, 64'h222, 5'd9, 1'b1, 64'h333);
        run_insn(OP_ADD, 5'd9, 5'd0, 5'd1, 64'h444, 64'h10, 64'd0, 64'h0);
        check("fwd mm alu", 64'h121, ex_result);
        set_bypass(5'd9, 1'b1, 1'b1, 64'h111, 64'h222, 5'd9, 1'b1, 64'h333);
        run_insn(OP_ADD, 5'd9, 5'd0, 5'd1, 64'h444, 64'h10, 64'd0, 64'h0);
        check("fwd mm mdata", 64'h232, ex_result);
        set_bypass(5'd9, 1'b0, 1'b1, 64'h111, 64'h222, 5'd9, 1'b1, 64'h333);
        run_insn(OP_ADD, 5'd9, 5'd0, 5'd1, 64'h444, 64'h10, 64'd0, 64'h0);
        check("fwd wb", 64'h343, ex_result);
        set_bypass(5'd9, 1'b0, 1'b1, 64'h111, 64'h222, 5'd9, 1'b0, 64'h333);
        run_insn(OP_ADD, 5'd9, 5'd0, 5'd1, 64'h444, 64'h10, 64'd0, 64'h0);
        check("no fwd flags clear", 64'h454, ex_result);
        set_bypass(5'd0, 1'b1, 1'b0, 64'h111, 64'h222, 5'd0, 1'b1, 64'h333);
        run_insn(OP_ADD, 5'd0, 5'd0, 5'd1, 64'h444, 64'h10, 64'd0, 64'h0);
        check("no fwd x0", 64'h454, ex_result);
        set_bypass(5'd0, 1'b0, 1'b0, 64'd0, 64'd0, 5'd0, 1'b0, 64'd0);
    endtask

    task automatic test_load_use();
        xlen_t addr;
        addr = 64'h0000_0000_8000_1238;
        @(posedge clk);
        set_insn(OP_LD, 5'd2, 5'd0, 5'd5, addr - 64'd8, 64'd0, 64'd8, 64'h3000);
        wait_accept();
        set_insn(OP_ADD, 5'd5, 5'd6, 5'd7, 64'd0, 64'd20, 64'd0, 64'h3004);
        @(negedge clk);
        check("ready stall", 64'd0, 64'(ready));
        check("ex_result load", addr, ex_result);
        // Stall edge, the load moves to the memory stage model
        @(posedge clk);
        mm_rd_regno   <= 5'd5;
        mm_write_rd   <= 1'b1;
        mm_load       <= 1'b1;
        mm_alu_result <= addr;
        mm_mdata      <= mem_data(addr);
        @(negedge clk);
        check("bubble ex_op", 64'(OP_NOP), 64'(ex_op));
        check("bubble ex_write_rd", 64'd0, 64'(ex_write_rd));
        check("ready after stall", 64'd1, 64'(ready));
        @(posedge clk);
        issue <= 1'b0;
        @(negedge clk);
        check("load-use result", mem_data(addr) + 64'd20, ex_result);
        set_bypass(5'd0, 1'b0, 1'b0, 64'd0, 64'd0, 5'd0, 1'b0, 64'd0);
    endtask

    task automatic test_squash_flush();
        @(posedge clk);
        set_insn(OP_JAL, 5'd0, 5'd0, 5'd1, 64'd0, 64'd0, 64'h40, 64'h5004);
        wait_accept();
        set_insn(OP_ADDI, 5'd0, 5'd0, 5'd4, 64'd0, 64'd0, 64'd1, 64'h5008);
        wait_accept();
        set_insn(OP_ADDI, 5'd0, 5'd0, 5'd4, 64'd0, 64'd0, 64'd2, 64'h5044);
        @(negedge clk);
        check("squash ex_op", 64'(OP_NOP), 64'(ex_op));
        check("squash ex_write_rd", 64'd0, 64'(ex_write_rd));
        @(posedge clk);
        issue <= 1'b0;
        @(negedge clk);
        check("after squash", 64'd2, ex_result);
        check("after squash ex_write_rd", 64'd1, 64'(ex_write_rd));
        @(posedge clk);
        set_insn(OP_ADDI, 5'd0, 5'd0, 5'd4, 64'd0, 64'd0, 64'd3, 64'h6000);
        flush <= 1'b1;
        wait_accept();
        issue <= 1'b0;
        flush <= 1'b0;
        @(negedge clk);
        check("flush ex_op", 64'(OP_NOP), 64'(ex_op));
        check("flush ex_write_rd", 64'd0, 64'(ex_write_rd));
    endtask

    initial
    begin
        issue <= 1'b0;
        flush <= 1'b0;
        op <= OP_NOP;
        rs1_regno <= '0;
        rs2_regno <= '0;
        rd_regno <= '0;
        rs1_value <= '0;
        rs2_value <= '0;
        imm <= '0;
        pc_next <= '0;
        mm_rd_regno <= '0;
        mm_write_rd <= 1'b0;
        mm_load <= 1'b0;
        mm_alu_result <= '0;
        mm_mdata <= '0;
        wb_rd_regno <= '0;
        wb_write_rd <= 1'b0;
        wb_data <= '0;
        test_reset_state();
        test_alu();
        test_mem_addr();
        test_branches();
        test_forwarding();
        test_load_use();
        test_squash_flush();
        finish_run();
    end

endmodule

//--- flist.f
+incdir+include
verilog/ex_types_pkg.sv
verilog/ex_op_pkg.sv
verilog/operand_forward.sv
verilog/int_alu.sv
verilog/branch_unit.sv
verilog/ex_result_reg.sv
verilog/execute_stage.sv
sim/ex_tb_clock.sv
sim/execute_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module execute_stage_tb -f flist.f -o ex_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    cat build.log
    exit 1
fi

./obj_dir/ex_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    exit 0
fi
exit 1
